// File: hw/cci_shim_defines.svh
/*
 * Shared sizing for the accelerator request path: field widths, buffer
 * depth, almost-full threshold and memory refresh timing
 */
`ifndef CCI_SHIM_DEFINES_SVH
`define CCI_SHIM_DEFINES_SVH

// Line address width, giving a 64-line memory
`define CCI_ADDR_BITS 6

// Line data width
`define CCI_DATA_BITS 32

// Request tag width, echoed back in every response
`define CCI_MDATA_BITS 8

// Almost-full rises when this many or fewer slots are free
`define CCI_ALMOST_FULL_THRESHOLD 2

// Buffer depth per channel, leaving slack above the threshold
`define CCI_FIFO_ENTRIES (`CCI_ALMOST_FULL_THRESHOLD + 4)

// Cycles from one refresh window to the next
`define CCI_REFRESH_PERIOD 16

// Length of each refresh window, in cycles
`define CCI_REFRESH_CYCLES 2

`endif

// File: hw/cci_req_pkg.sv
/*
 * Accelerator-side request types for the read and write channels
 */
`default_nettype none

`include "cci_shim_defines.svh"

package cci_req_pkg;

    // Field types shared by both channels and by the memory side
    typedef logic [`CCI_ADDR_BITS-1:0]  addr_t;
    typedef logic [`CCI_DATA_BITS-1:0]  data_t;
    typedef logic [`CCI_MDATA_BITS-1:0] mdata_t;

    // Request opcodes
    // Channel 0 only carries RD_LINE and channel 1 carries the other two
    typedef enum logic [1:0] {
        RD_LINE  = 2'd0,
        WR_LINE  = 2'd1,
        WR_FENCE = 2'd2
    } req_op_e;

    // Channel 0 read request
    // The valid bit must stay the leading field, since the buffer stage
    // strips it off the top of the struct before storing the payload
    typedef struct packed {
        logic    valid;
        req_op_e op;
        addr_t   addr;
        mdata_t  mdata;
    } c0_req_t;

    // Channel 1 write or fence request
    // Same rule for the leading valid bit as on channel 0
    // A fence carries no meaningful address or data
    typedef struct packed {
        logic    valid;
        req_op_e op;
        addr_t   addr;
        data_t   data;
        mdata_t  mdata;
    } c1_req_t;

endpackage

`default_nettype wire

// File: hw/cci_mem_pkg.sv
/*
 * Memory-side types: the single issued request and the two response channels
 */
`default_nettype none

package cci_mem_pkg;

    // Kind of acknowledgement returned on the channel 1 response port
    typedef enum logic {
        ACK_WRITE = 1'b0,
        ACK_FENCE = 1'b1
    } ack_kind_e;

    // One request as issued by the arbiter
    // Data is only meaningful for WR_LINE and is zero otherwise
    typedef struct packed {
        logic                 valid;
        cci_req_pkg::req_op_e op;
        cci_req_pkg::addr_t   addr;
        cci_req_pkg::data_t   data;
        cci_req_pkg::mdata_t  mdata;
    } mem_req_t;

    // Read data response on channel 0
    typedef struct packed {
        logic                valid;
        cci_req_pkg::data_t  data;
        cci_req_pkg::mdata_t mdata;
    } c0_rsp_t;

    // Write or fence acknowledgement on channel 1
    typedef struct packed {
        logic                valid;
        ack_kind_e           kind;
        cci_req_pkg::mdata_t mdata;
    } c1_rsp_t;

endpackage

`default_nettype wire

// File: hw/cci_lutram_fifo.sv
/*
 * Small circular FIFO with first-word output, a not-empty flag and a
 * registered almost-full flag driven from the free-slot count
 */
`timescale 1ns/1ns
`default_nettype none

module cci_lutram_fifo #(
    parameter int N_DATA_BITS = 16,
    parameter int N_ENTRIES   = 6,
    parameter int THRESHOLD   = 2
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    input  wire logic [N_DATA_BITS-1:0] enq_data,
    input  wire logic                   enq_en,

    input  wire logic                   deq_en,
    output logic      [N_DATA_BITS-1:0] first,
    output logic                        not_empty,

    output logic                        almost_full
);

    // Pointer and counter widths
    // The counter needs one extra state to represent a full buffer
    localparam int PW = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;
    localparam int CW = $clog2(N_ENTRIES + 1);

    localparam logic [PW-1:0] PTR_LAST = PW'(N_ENTRIES - 1);
    localparam logic [CW-1:0] FULL_CNT = CW'(N_ENTRIES);

    // Occupancy at which THRESHOLD or fewer slots remain free
    localparam logic [CW-1:0] AF_LEVEL = CW'(N_ENTRIES - THRESHOLD);

    logic [N_DATA_BITS-1:0] mem [N_ENTRIES];
    logic [PW-1:0]          wr_ptr;
    logic [PW-1:0]          rd_ptr;
    logic [CW-1:0]          count;
    logic [CW-1:0]          count_next;

    // Payload storage, written at the tail
    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    // The oldest entry is always visible at the head
    assign first     = mem[rd_ptr];
    assign not_empty = (count != '0);

    // Occupancy after this edge, also feeding the almost-full register
    assign count_next = count + CW'(enq_en) - CW'(deq_en);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            almost_full <= 1'b0;
        end
        else
        begin
            // Depth need not be a power of two, so pointers wrap explicitly
            if (enq_en)
            begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (deq_en)
            begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            count       <= count_next;
            almost_full <= (count_next >= AF_LEVEL);
        end
    end

    // The producer must have honoured almost_full early enough to never
    // push into a full buffer
    assert property (@(posedge clk) disable iff (!rst_n)
        enq_en |-> (count != FULL_CNT));

    // The consumer only dequeues a head that exists
    assert property (@(posedge clk) disable iff (!rst_n)
        deq_en |-> not_empty);

endmodule

`default_nettype wire

// File: hw/cci_shim_buffer_afu.sv
/*
 * Buffer stage: latency-insensitive request FIFOs for the read and write
 * channels, consumed by explicit dequeue, with an optional read bypass
 */
`timescale 1ns/1ns
`default_nettype none

`include "cci_shim_defines.svh"

module cci_shim_buffer_afu #(
    parameter bit ENABLE_C0_BYPASS = 1'b0
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,

    // Raw requests from the accelerator
    input  wire cci_req_pkg::c0_req_t c0_tx,
    input  wire cci_req_pkg::c1_req_t c1_tx,
    output logic                      c0_almost_full,
    output logic                      c1_almost_full,

    // Buffered heads toward the arbiter
    // A head stays put until its dequeue is raised
    output cci_req_pkg::c0_req_t      c0_head,
    output cci_req_pkg::c1_req_t      c1_head,
    input  wire logic                 deq_c0,
    input  wire logic                 deq_c1
);

    // The valid bit is not stored
    // Not-empty from the FIFO stands in for it at the head
    localparam int C0_BITS = $bits(cci_req_pkg::c0_req_t) - 1;
    localparam int C1_BITS = $bits(cci_req_pkg::c1_req_t) - 1;

    // ==========================================================
    // Channel 0 (reads)
    // ==========================================================

    logic [C0_BITS-1:0] c0_first;
    logic               c0_not_empty;
    logic               c0_enq;
    logic               c0_deq;

    if (ENABLE_C0_BYPASS)
    begin : g_c0_bypass
        // While the FIFO is empty the raw request is offered straight to
        // the arbiter in the same cycle
        always_comb
        begin
            if (c0_not_empty)
            begin
                c0_head = cci_req_pkg::c0_req_t'({1'b1, c0_first});
            end
            else
            begin
                c0_head = c0_tx;
            end
        end

        // A new request only lands in the FIFO if the bypass did not
        // consume it right away
        assign c0_enq = c0_tx.valid && (c0_not_empty || !deq_c0);

        // A dequeue with an empty FIFO was taken by the bypass
        assign c0_deq = deq_c0 && c0_not_empty;
    end
    else
    begin : g_c0_no_bypass
        // Every request goes through the FIFO
        assign c0_head = cci_req_pkg::c0_req_t'({c0_not_empty, c0_first});
        assign c0_enq  = c0_tx.valid;
        assign c0_deq  = deq_c0;
    end

    cci_lutram_fifo #(
        .N_DATA_BITS (C0_BITS),
        .N_ENTRIES   (`CCI_FIFO_ENTRIES),
        .THRESHOLD   (`CCI_ALMOST_FULL_THRESHOLD)
    ) u_c0_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .enq_data    (c0_tx[C0_BITS-1:0]),
        .enq_en      (c0_enq),
        .deq_en      (c0_deq),
        .first       (c0_first),
        .not_empty   (c0_not_empty),
        .almost_full (c0_almost_full)
    );

    // ==========================================================
    // Channel 1 (writes and fences)
    // ==========================================================

    // No bypass here, store traffic is not latency critical
    logic [C1_BITS-1:0] c1_first;
    logic               c1_not_empty;

    assign c1_head = cci_req_pkg::c1_req_t'({c1_not_empty, c1_first});

    cci_lutram_fifo #(
        .N_DATA_BITS (C1_BITS),
        .N_ENTRIES   (`CCI_FIFO_ENTRIES),
        .THRESHOLD   (`CCI_ALMOST_FULL_THRESHOLD)
    ) u_c1_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .enq_data    (c1_tx[C1_BITS-1:0]),
        .enq_en      (c1_tx.valid),
        .deq_en      (deq_c1),
        .first       (c1_first),
        .not_empty   (c1_not_empty),
        .almost_full (c1_almost_full)
    );

endmodule

`default_nettype wire

// File: hw/cci_req_arbiter.sv
/*
 * Arbiter stage: picks one channel head per ready cycle with alternating
 * priority, dequeues it and presents it to memory
 */
`timescale 1ns/1ns
`default_nettype none

module cci_req_arbiter (
    input  wire logic                 clk,
    input  wire logic                 rst_n,

    input  wire cci_req_pkg::c0_req_t c0_head,
    input  wire cci_req_pkg::c1_req_t c1_head,
    output logic                      deq_c0,
    output logic                      deq_c1,

    output cci_mem_pkg::mem_req_t     mem_req,
    input  wire logic                 mem_ready
);

    // Channel that won the most recent issue
    typedef enum logic {
        GRANT_C0 = 1'b0,
        GRANT_C1 = 1'b1
    } grant_e;

    grant_e last_grant;
    logic   pick_c0;
    logic   pick_c1;

    // On a tie the channel not granted last wins
    // A lone valid head always wins
    assign pick_c0 = c0_head.valid && (!c1_head.valid || (last_grant == GRANT_C1));
    assign pick_c1 = c1_head.valid && !pick_c0;

    // Nothing leaves the buffers while memory is refreshing
    assign deq_c0 = mem_ready && pick_c0;
    assign deq_c1 = mem_ready && pick_c1;

    // Format the chosen head as a memory request
    always_comb
    begin
        mem_req = '0;
        if (deq_c0)
        begin
            // Reads carry no data
            mem_req.valid = 1'b1;
            mem_req.op    = c0_head.op;
            mem_req.addr  = c0_head.addr;
            mem_req.mdata = c0_head.mdata;
        end
        else if (deq_c1)
        begin
            mem_req.valid = 1'b1;
            mem_req.op    = c1_head.op;
            mem_req.addr  = c1_head.addr;
            mem_req.data  = c1_head.data;
            mem_req.mdata = c1_head.mdata;
        end
    end

    // Starting from GRANT_C1 lets a read win the very first tie
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            last_grant <= GRANT_C1;
        end
        else if (deq_c0 || deq_c1)
        begin
            last_grant <= deq_c1 ? GRANT_C1 : GRANT_C0;
        end
    end

    // Only one buffer may give up its head in any cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        !(deq_c0 && deq_c1));

endmodule

`default_nettype wire

// File: hw/cci_mem_model.sv
/*
 * Memory stage: line storage with periodic refresh windows that stall
 * issue, returning read data and write or fence acknowledgements
 */
`timescale 1ns/1ns
`default_nettype none

`include "cci_shim_defines.svh"

module cci_mem_model (
    input  wire logic                  clk,
    input  wire logic                  rst_n,

    input  wire cci_mem_pkg::mem_req_t mem_req,
    output logic                       mem_ready,

    output cci_mem_pkg::c0_rsp_t       c0_rx,
    output cci_mem_pkg::c1_rsp_t       c1_rx
);

    localparam int LINES = 2 ** `CCI_ADDR_BITS;
    localparam int RW    = $clog2(`CCI_REFRESH_PERIOD);

    // First count value of the refresh window, where requests stop being accepted
    localparam logic [RW-1:0] READY_LIMIT = RW'(`CCI_REFRESH_PERIOD - `CCI_REFRESH_CYCLES);
    localparam logic [RW-1:0] CNT_LAST    = RW'(`CCI_REFRESH_PERIOD - 1);

    cci_req_pkg::data_t mem [LINES];
    logic [RW-1:0]      refresh_cnt;

    // Request captured at the issue edge
    logic                 req_q_valid;
    cci_req_pkg::req_op_e req_q_op;
    cci_req_pkg::addr_t   req_q_addr;
    cci_req_pkg::mdata_t  req_q_mdata;

    // Response registers
    logic                   rsp0_valid;
    cci_req_pkg::data_t     rsp0_data;
    cci_req_pkg::mdata_t    rsp0_mdata;
    logic                   rsp1_valid;
    cci_mem_pkg::ack_kind_e rsp1_kind;
    cci_req_pkg::mdata_t    rsp1_mdata;

    // ==========================================================
    // Refresh timing
    // ==========================================================

    // The last two counts of every period form the refresh window
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            refresh_cnt <= '0;
        end
        else
        begin
            refresh_cnt <= (refresh_cnt == CNT_LAST) ? '0 : refresh_cnt + 1'b1;
        end
    end

    assign mem_ready = (refresh_cnt < READY_LIMIT);

    // ==========================================================
    // Storage and response pipeline
    // ==========================================================

    // Writes land at the issue edge, fences leave storage untouched
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < LINES; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (mem_req.valid && (mem_req.op == cci_req_pkg::WR_LINE))
        begin
            mem[mem_req.addr] <= mem_req.data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            req_q_valid <= 1'b0;
            rsp0_valid  <= 1'b0;
            rsp1_valid  <= 1'b0;
        end
        else
        begin
            req_q_valid <= mem_req.valid;
            rsp0_valid  <= req_q_valid && (req_q_op == cci_req_pkg::RD_LINE);
            rsp1_valid  <= req_q_valid && (req_q_op != cci_req_pkg::RD_LINE);
        end
    end

    // Payload of both stages, qualified by the valid registers above
    // A read sees every write issued before it, since those are stored by now
    always_ff @(posedge clk)
    begin
        req_q_op    <= mem_req.op;
        req_q_addr  <= mem_req.addr;
        req_q_mdata <= mem_req.mdata;
        rsp0_data   <= mem[req_q_addr];
        rsp0_mdata  <= req_q_mdata;
        rsp1_kind   <= (req_q_op == cci_req_pkg::WR_FENCE) ? cci_mem_pkg::ACK_FENCE
                                                          : cci_mem_pkg::ACK_WRITE;
        rsp1_mdata  <= req_q_mdata;
    end

    always_comb
    begin
        c0_rx.valid = rsp0_valid;
        c0_rx.data  = rsp0_data;
        c0_rx.mdata = rsp0_mdata;
        c1_rx.valid = rsp1_valid;
        c1_rx.kind  = rsp1_kind;
        c1_rx.mdata = rsp1_mdata;
    end

    // The arbiter must hold requests back through every refresh window
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.valid |-> mem_ready);

endmodule

`default_nettype wire

// File: hw/cci_shim_pipe.sv
/*
 * Top level of the request path: buffer, arbiter and memory stages
 */
`timescale 1ns/1ns
`default_nettype none

module cci_shim_pipe #(
    parameter bit ENABLE_C0_BYPASS = 1'b1
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,

    input  wire cci_req_pkg::c0_req_t c0_tx,
    input  wire cci_req_pkg::c1_req_t c1_tx,
    output logic                      c0_almost_full,
    output logic                      c1_almost_full,

    // Responses leave unbuffered, the accelerator cannot stall them
    output cci_mem_pkg::c0_rsp_t      c0_rx,
    output cci_mem_pkg::c1_rsp_t      c1_rx
);

    cci_req_pkg::c0_req_t  c0_head;
    cci_req_pkg::c1_req_t  c1_head;
    logic                  deq_c0;
    logic                  deq_c1;
    cci_mem_pkg::mem_req_t mem_req;
    logic                  mem_ready;

    cci_shim_buffer_afu #(
        .ENABLE_C0_BYPASS (ENABLE_C0_BYPASS)
    ) u_buffer (
        .clk            (clk),
        .rst_n          (rst_n),
        .c0_tx          (c0_tx),
        .c1_tx          (c1_tx),
        .c0_almost_full (c0_almost_full),
        .c1_almost_full (c1_almost_full),
        .c0_head        (c0_head),
        .c1_head        (c1_head),
        .deq_c0         (deq_c0),
        .deq_c1         (deq_c1)
    );

    cci_req_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .c0_head   (c0_head),
        .c1_head   (c1_head),
        .deq_c0    (deq_c0),
        .deq_c1    (deq_c1),
        .mem_req   (mem_req),
        .mem_ready (mem_ready)
    );

    cci_mem_model u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_ready (mem_ready),
        .c0_rx     (c0_rx),
        .c1_rx     (c1_rx)
    );

endmodule

`default_nettype wire

// File: test/tb_cci_shim_pipe.sv
/*
 * Directed testbench for the request path, checking every response
 * against a reference memory and per-channel expectation queues
 */
`timescale 1ns/1ns
`default_nettype none

`include "cci_shim_defines.svh"

module tb_cci_shim_pipe;

    localparam int CLK_PERIOD = 4;
    localparam int BURST_CAP  = 48;
    // Request counts of all tests added up, for the watchdog
    localparam int TOTAL_REQS = 8 + 32 + 7 + 80 + 2 * BURST_CAP + 6;
    localparam int TIMEOUT_NS = (TOTAL_REQS * 8 + 400) * CLK_PERIOD;
    localparam logic [31:0] LFSR_MASK = 32'h8020_0003;

    logic                  clk;
    logic                  rst_n;
    cci_req_pkg::c0_req_t  c0_tx;
    cci_req_pkg::c1_req_t  c1_tx;
    logic                  c0_almost_full;
    logic                  c1_almost_full;
    cci_mem_pkg::c0_rsp_t  c0_rx;
    cci_mem_pkg::c1_rsp_t  c1_rx;

    // Reference state and expectations in issue order
    cci_req_pkg::data_t     ref_mem [2 ** `CCI_ADDR_BITS];
    cci_req_pkg::mdata_t    exp_c0_mdata [$];
    cci_req_pkg::data_t     exp_c0_data [$];
    cci_req_pkg::mdata_t    exp_c1_mdata [$];
    cci_mem_pkg::ack_kind_e exp_c1_kind [$];
    cci_req_pkg::mdata_t    c0_tag;
    cci_req_pkg::mdata_t    c1_tag;
    logic [31:0]            lfsr_state;
    int                     req_count;
    int                     rsp_count;
    cci_req_pkg::mdata_t    exp_mdata;
    cci_req_pkg::data_t     exp_data;
    cci_mem_pkg::ack_kind_e exp_kind;

    cci_shim_pipe #(
        .ENABLE_C0_BYPASS (1'b1)
    ) u_cci_shim_pipe (
        .clk            (clk),
        .rst_n          (rst_n),
        .c0_tx          (c0_tx),
        .c1_tx          (c1_tx),
        .c0_almost_full (c0_almost_full),
        .c1_almost_full (c1_almost_full),
        .c0_rx          (c0_rx),
        .c1_rx          (c1_rx)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // ============================================================
    // Reporting and random values
    // ============================================================

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, actual);
        $display("Errors found");
        $fatal(1);
    endtask

    // Galois LFSR shifting right, one step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            b          = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b)
            begin
                lfsr_state = lfsr_state ^ LFSR_MASK;
            end
            v = {v[30:0], b};
        end
        return v;
    endfunction

    // Lower half of memory is read-mostly, upper half takes bulk writes
    function automatic cci_req_pkg::addr_t low_addr();
        logic [31:0] v;
        v = rand_bits(5);
        return {1'b0, v[4:0]};
    endfunction

    function automatic cci_req_pkg::addr_t high_addr();
        logic [31:0] v;
        v = rand_bits(5);
        return {1'b1, v[4:0]};
    endfunction

    // ============================================================
    // Request building and driving
    // ============================================================

    function automatic cci_req_pkg::c0_req_t read_req(input cci_req_pkg::addr_t addr);
        cci_req_pkg::c0_req_t r;
        r       = '0;
        r.valid = 1'b1;
        r.op    = cci_req_pkg::RD_LINE;
        r.addr  = addr;
        r.mdata = c0_tag;
        c0_tag  = c0_tag + 1'b1;
        return r;
    endfunction

    function automatic cci_req_pkg::c1_req_t write_req(input cci_req_pkg::addr_t addr,
                                                       input cci_req_pkg::data_t data);
        cci_req_pkg::c1_req_t r;
        r       = '0;
        r.valid = 1'b1;
        r.op    = cci_req_pkg::WR_LINE;
        r.addr  = addr;
        r.data  = data;
        r.mdata = c1_tag;
        c1_tag  = c1_tag + 1'b1;
        return r;
    endfunction

    function automatic cci_req_pkg::c1_req_t fence_req();
        cci_req_pkg::c1_req_t r;
        r       = '0;
        r.valid = 1'b1;
        r.op    = cci_req_pkg::WR_FENCE;
        r.mdata = c1_tag;
        c1_tag  = c1_tag + 1'b1;
        return r;
    endfunction

    // Called just after a falling edge; records what each request must return
    task automatic drive_requests(input cci_req_pkg::c0_req_t r0,
                                  input cci_req_pkg::c1_req_t r1);
        c0_tx = r0;
        c1_tx = r1;
        if (r0.valid)
        begin
            exp_c0_mdata.push_back(r0.mdata);
            exp_c0_data.push_back(ref_mem[r0.addr]);
            req_count++;
        end
        if (r1.valid)
        begin
            exp_c1_mdata.push_back(r1.mdata);
            if (r1.op == cci_req_pkg::WR_LINE)
            begin
                exp_c1_kind.push_back(cci_mem_pkg::ACK_WRITE);
                ref_mem[r1.addr] = r1.data;
            end
            else
            begin
                exp_c1_kind.push_back(cci_mem_pkg::ACK_FENCE);
            end
            req_count++;
        end
    endtask

    // Lone requests hold off while their channel reports almost-full
    task automatic send_read(input cci_req_pkg::addr_t addr);
        @(negedge clk);
        while (c0_almost_full)
        begin
            drive_requests('0, '0);
            @(negedge clk);
        end
        drive_requests(read_req(addr), '0);
    endtask

    task automatic send_c1(input cci_req_pkg::c1_req_t r);
        @(negedge clk);
        while (c1_almost_full)
        begin
            drive_requests('0, '0);
            @(negedge clk);
        end
        drive_requests('0, r);
    endtask

    task automatic go_idle();
        @(negedge clk);
        drive_requests('0, '0);
    endtask

    // Wait until every outstanding request has been answered
    task automatic wait_drained();
        while (exp_c0_mdata.size() != 0 || exp_c1_mdata.size() != 0)
        begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
    endtask

    // ============================================================
    // Response monitor
    // ============================================================

    // Responses are registered, so mid-cycle sampling sees settled values
    always @(negedge clk)
    begin
        if (rst_n && c0_rx.valid)
        begin
            assert (exp_c0_mdata.size() != 0)
            else abort_run("Read response arrived with no read outstanding");
            exp_mdata = exp_c0_mdata.pop_front();
            exp_data  = exp_c0_data.pop_front();
            assert (c0_rx.mdata == exp_mdata)
            else report_mismatch("c0_rx.mdata", 32'(exp_mdata), 32'(c0_rx.mdata));
            assert (c0_rx.data == exp_data)
            else report_mismatch("c0_rx.data", exp_data, c0_rx.data);
            rsp_count++;
        end
        if (rst_n && c1_rx.valid)
        begin
            assert (exp_c1_mdata.size() != 0)
            else abort_run("Write acknowledgement arrived with no write outstanding");
            exp_mdata = exp_c1_mdata.pop_front();
            exp_kind  = exp_c1_kind.pop_front();
            assert (c1_rx.mdata == exp_mdata)
            else report_mismatch("c1_rx.mdata", 32'(exp_mdata), 32'(c1_rx.mdata));
            assert (c1_rx.kind == exp_kind)
            else report_mismatch("c1_rx.kind", 32'(exp_kind), 32'(c1_rx.kind));
            rsp_count++;
        end
    end

    // ============================================================
    // Directed tests
    // ============================================================

    // Flags and response valids idle after reset, unwritten lines read zero
    task automatic check_reset_state();
        assert (!c0_almost_full) else report_mismatch("c0_almost_full", 0, c0_almost_full);
        assert (!c1_almost_full) else report_mismatch("c1_almost_full", 0, c1_almost_full);
        assert (!c0_rx.valid) else report_mismatch("c0_rx.valid", 0, c0_rx.valid);
        assert (!c1_rx.valid) else report_mismatch("c1_rx.valid", 0, c1_rx.valid);
        for (int i = 0; i < 8; i++)
        begin
            send_read(cci_req_pkg::addr_t'(rand_bits(6)));
        end
        go_idle();
        wait_drained();
    endtask

    task automatic write_then_read();
        cci_req_pkg::addr_t addrs [16];
        for (int i = 0; i < 16; i++)
        begin
            addrs[i] = low_addr();
            send_c1(write_req(addrs[i], rand_bits(32)));
        end
        go_idle();
        wait_drained();
        for (int i = 0; i < 16; i++)
        begin
            send_read(addrs[i]);
        end
        go_idle();
        wait_drained();
    endtask

    // The fence's acknowledgement is queued behind all six writes
    task automatic fence_ordering();
        for (int i = 0; i < 6; i++)
        begin
            send_c1(write_req(low_addr(), rand_bits(32)));
        end
        send_c1(fence_req());
        go_idle();
        wait_drained();
    endtask

    // Both channels every cycle across several refresh windows
    task automatic refresh_traffic();
        int                   reads_left;
        int                   writes_left;
        cci_req_pkg::c0_req_t r0;
        cci_req_pkg::c1_req_t r1;
        reads_left  = 40;
        writes_left = 40;
        while (reads_left > 0 || writes_left > 0)
        begin
            @(negedge clk);
            r0 = '0;
            r1 = '0;
            if (reads_left > 0 && !c0_almost_full)
            begin
                r0 = read_req(low_addr());
                reads_left--;
            end
            if (writes_left > 0 && !c1_almost_full)
            begin
                r1 = (writes_left % 8 == 1) ? fence_req() : write_req(high_addr(), rand_bits(32));
                writes_left--;
            end
            drive_requests(r0, r1);
        end
        go_idle();
        wait_drained();
    endtask

    // Write burst on channel 1 while background reads take every other
    // issue slot, so the write FIFO backs up until its flag rises
    task automatic almost_full_burst();
        int                   sent;
        int                   req_before;
        int                   rsp_before;
        logic                 rose;
        cci_req_pkg::c0_req_t r0;
        sent       = 0;
        rose       = 1'b0;
        req_before = req_count;
        rsp_before = rsp_count;
        while (sent < BURST_CAP && !rose)
        begin
            @(negedge clk);
            r0 = '0;
            if (c1_almost_full)
            begin
                rose = 1'b1;
                drive_requests('0, '0);
            end
            else
            begin
                if (!c0_almost_full)
                begin
                    r0 = read_req(low_addr());
                end
                drive_requests(r0, write_req(high_addr(), rand_bits(32)));
                sent++;
            end
        end
        go_idle();
        assert (rose) else abort_run("c1_almost_full never rose during a write burst");
        wait_drained();
        assert (rsp_count - rsp_before == req_count - req_before)
        else report_mismatch("burst response count", req_count - req_before,
                             rsp_count - rsp_before);
        assert (!c1_almost_full) else report_mismatch("c1_almost_full", 0, c1_almost_full);
        assert (!c0_almost_full) else report_mismatch("c0_almost_full", 0, c0_almost_full);
    endtask

    // Lone reads into an idle pipeline, landing at different refresh phases
    task automatic bypass_read();
        for (int gap = 0; gap < 6; gap++)
        begin
            repeat (gap * 3) @(negedge clk);
            send_read(low_addr());
            go_idle();
            wait_drained();
        end
    endtask

    initial
    begin
        rst_n      = 1'b0;
        c0_tx      = '0;
        c1_tx      = '0;
        c0_tag     = '0;
        c1_tag     = '0;
        lfsr_state = 32'h9766_dbfe;
        req_count  = 0;
        rsp_count  = 0;
        for (int i = 0; i < 2 ** `CCI_ADDR_BITS; i++)
        begin
            ref_mem[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        check_reset_state();
        write_then_read();
        fence_ordering();
        refresh_traffic();
        almost_full_burst();
        bypass_read();

        if (rsp_count == req_count)
        begin
            $display("No errors");
            $finish;
        end
        else
        begin
            $display("[FAIL] %0t ns response count expected %0d got %0d",
                     $time, req_count, rsp_count);
            $display("Errors found");
            $fatal(1);
        end
    end

    // Watchdog against a stalled pipeline
    initial
    begin
        #(TIMEOUT_NS);
        abort_run("Watchdog expired before all tests completed");
    end

endmodule

`default_nettype wire

// File: cci_shim_pipe.f
+incdir+hw
hw/cci_req_pkg.sv
hw/cci_mem_pkg.sv
hw/cci_lutram_fifo.sv
hw/cci_shim_buffer_afu.sv
hw/cci_req_arbiter.sv
hw/cci_mem_model.sv
hw/cci_shim_pipe.sv
test/tb_cci_shim_pipe.sv

// File: Bender.yml
package:
  name: cci_shim_pipe

export_include_dirs:
  - hw

sources:
  - files:
      - hw/cci_req_pkg.sv
      - hw/cci_mem_pkg.sv
      - hw/cci_lutram_fifo.sv
      - hw/cci_shim_buffer_afu.sv
      - hw/cci_req_arbiter.sv
      - hw/cci_mem_model.sv
      - hw/cci_shim_pipe.sv
  - target: test
    files:
      - test/tb_cci_shim_pipe.sv
